// ==== cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 9;
    localparam int memDepth  = 512;
    localparam int regCount  = 16;
    localparam int regSel    = 4;

    // Instruction opcodes in IR[31:27]
    localparam logic [4:0] opLd   = 5'b00000;
    localparam logic [4:0] opLdi  = 5'b00001;
    localparam logic [4:0] opSt   = 5'b00010;
    localparam logic [4:0] opAdd  = 5'b00011;
    localparam logic [4:0] opSub  = 5'b00100;
    localparam logic [4:0] opAnd  = 5'b01010;
    localparam logic [4:0] opOr   = 5'b01011;
    localparam logic [4:0] opAddi = 5'b01100;
    localparam logic [4:0] opAndi = 5'b01101;
    localparam logic [4:0] opOri  = 5'b01110;
    localparam logic [4:0] opBrzr = 5'b10011;
    localparam logic [4:0] opIn   = 5'b10110;
    localparam logic [4:0] opOut  = 5'b10111;
    localparam logic [4:0] opNop  = 5'b11010;
    localparam logic [4:0] opHalt = 5'b11011;
    localparam logic [4:0] opBrnz = 5'b11100;

    // IR field positions
    localparam int opHi   = 31;
    localparam int opLo   = 27;
    localparam int raHi   = 26;
    localparam int raLo   = 23;
    localparam int rbHi   = 22;
    localparam int rbLo   = 19;
    localparam int rcHi   = 18;
    localparam int rcLo   = 15;
    localparam int cHi    = 18;
    localparam int cLo    = 0;
    localparam int condHi = 20;
    localparam int condLo = 19;

    localparam logic [1:0] condZero    = 2'b00;
    localparam logic [1:0] condNonzero = 2'b01;

    // Timing steps
    localparam logic [3:0] stepReset = 4'd0;
    localparam logic [3:0] stepT0    = 4'd1;
    localparam logic [3:0] stepT1    = 4'd2;
    localparam logic [3:0] stepT2    = 4'd3;
    localparam logic [3:0] stepT3    = 4'd4;
    localparam logic [3:0] stepT4    = 4'd5;
    localparam logic [3:0] stepT5    = 4'd6;
    localparam logic [3:0] stepT6    = 4'd7;
    localparam logic [3:0] stepT7    = 4'd8;

    // ALU operation codes
    localparam logic [4:0] aluAdd   = 5'b00011;
    localparam logic [4:0] aluSub   = 5'b00100;
    localparam logic [4:0] aluAnd   = 5'b01010;
    localparam logic [4:0] aluOr    = 5'b01011;
    localparam logic [4:0] aluPassB = 5'b11111;

endpackage

// ==== control.sv ====
`timescale 1ns/1ps

module control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stop,
    input  logic [cpuPkg::dataWidth-1:0]  IR,
    input  logic                          conFf,
    output logic                          pcOut, mdrOut, zOut, cOut, inportOut,
    output logic                          marIn, zIn, pcIn, mdrIn, irIn, yIn,
    output logic                          conIn, outportIn, incPc,
    output logic [4:0]                    aluOp,
    output logic                          memRead, memWrite,
    output logic                          run, clear,
    output logic                          Gra, Grb, Grc, Rin, Rout, BAout
);

    logic [3:0] step;
    logic [3:0] nextStep;
    logic       runReg;
    logic       active;
    logic [4:0] opcode;
    logic [4:0] opAlu;
    logic       regForm;  // Rc supplies the second operand
    logic       memForm;  // ld or st
    logic       baseForm; // Rb read under BAout

    assign opcode = IR[cpuPkg::opHi:cpuPkg::opLo];
    assign active = runReg && !stop;
    assign run    = runReg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step   <= cpuPkg::stepReset;
            runReg <= 1'b1;
        end else begin
            step <= nextStep;
            if (clear) begin
                runReg <= 1'b0; // Halt sticks until reset
            end
        end
    end

    // Instruction class and ALU operation
    always_comb begin
        regForm  = 1'b0;
        memForm  = 1'b0;
        baseForm = 1'b0;
        opAlu    = cpuPkg::aluPassB;
        case (opcode)
            cpuPkg::opAdd: begin
                regForm = 1'b1;
                opAlu   = cpuPkg::aluAdd;
            end
            cpuPkg::opSub: begin
                regForm = 1'b1;
                opAlu   = cpuPkg::aluSub;
            end
            cpuPkg::opAnd: begin
                regForm = 1'b1;
                opAlu   = cpuPkg::aluAnd;
            end
            cpuPkg::opOr: begin
                regForm = 1'b1;
                opAlu   = cpuPkg::aluOr;
            end
            cpuPkg::opAddi: opAlu = cpuPkg::aluAdd;
            cpuPkg::opAndi: opAlu = cpuPkg::aluAnd;
            cpuPkg::opOri:  opAlu = cpuPkg::aluOr;
            cpuPkg::opLdi: begin
                baseForm = 1'b1;
                opAlu    = cpuPkg::aluAdd;
            end
            cpuPkg::opLd, cpuPkg::opSt: begin
                baseForm = 1'b1;
                memForm  = 1'b1;
                opAlu    = cpuPkg::aluAdd; // Base plus offset
            end
            default: opAlu = cpuPkg::aluPassB;
        endcase
    end

    always_comb begin
        {pcOut, mdrOut, zOut, cOut, inportOut} = '0;
        {marIn, zIn, pcIn, mdrIn, irIn, yIn, conIn, outportIn, incPc} = '0;
        {memRead, memWrite, clear} = '0;
        {Gra, Grb, Grc, Rin, Rout, BAout} = '0;
        aluOp    = '0;
        nextStep = step; // Held under stop or after halt
        if (active) begin
            nextStep = step + 4'd1;
            case (step)
                cpuPkg::stepReset: nextStep = cpuPkg::stepT0;
                cpuPkg::stepT0: begin
                    pcOut = 1'b1;
                    marIn = 1'b1;
                    incPc = 1'b1;
                end
                cpuPkg::stepT1: begin
                    memRead = 1'b1;
                    mdrIn   = 1'b1;
                end
                cpuPkg::stepT2: begin
                    mdrOut = 1'b1;
                    irIn   = 1'b1;
                end
                default: begin
                    case (opcode)
                        cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                        cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri,
                        cpuPkg::opLdi, cpuPkg::opLd, cpuPkg::opSt: begin
                            case (step)
                                cpuPkg::stepT3: begin
                                    Grb   = 1'b1;
                                    yIn   = 1'b1;
                                    Rout  = !baseForm;
                                    BAout = baseForm;
                                end
                                cpuPkg::stepT4: begin
                                    zIn   = 1'b1;
                                    aluOp = opAlu;
                                    Grc   = regForm;
                                    Rout  = regForm;
                                    cOut  = !regForm; // Immediate in Rc's place
                                end
                                cpuPkg::stepT5: begin
                                    zOut = 1'b1;
                                    if (memForm) begin
                                        marIn = 1'b1;
                                    end else begin
                                        Gra      = 1'b1;
                                        Rin      = 1'b1;
                                        nextStep = cpuPkg::stepT0;
                                    end
                                end
                                cpuPkg::stepT6: begin
                                    mdrIn = 1'b1;
                                    if (opcode == cpuPkg::opLd) begin
                                        memRead = 1'b1;
                                    end else begin
                                        Gra  = 1'b1; // Store data from Ra
                                        Rout = 1'b1;
                                    end
                                end
                                cpuPkg::stepT7: begin
                                    nextStep = cpuPkg::stepT0;
                                    if (opcode == cpuPkg::opLd) begin
                                        mdrOut = 1'b1;
                                        Gra    = 1'b1;
                                        Rin    = 1'b1;
                                    end else begin
                                        memWrite = 1'b1;
                                    end
                                end
                                default: nextStep = cpuPkg::stepT0;
                            endcase
                        end
                        cpuPkg::opBrzr, cpuPkg::opBrnz: begin
                            case (step)
                                cpuPkg::stepT3: begin
                                    Gra   = 1'b1;
                                    Rout  = 1'b1;
                                    conIn = 1'b1;
                                end
                                cpuPkg::stepT4: begin
                                    pcOut = 1'b1;
                                    yIn   = 1'b1;
                                end
                                default: begin
                                    cOut     = 1'b1;
                                    aluOp    = cpuPkg::aluAdd;
                                    pcIn     = conFf; // Taken only when flag set
                                    nextStep = cpuPkg::stepT0;
                                end
                            endcase
                        end
                        cpuPkg::opIn: begin
                            inportOut = 1'b1;
                            Gra       = 1'b1;
                            Rin       = 1'b1;
                            nextStep  = cpuPkg::stepT0;
                        end
                        cpuPkg::opOut: begin
                            Gra       = 1'b1;
                            Rout      = 1'b1;
                            outportIn = 1'b1;
                            nextStep  = cpuPkg::stepT0;
                        end
                        cpuPkg::opHalt: begin
                            clear    = 1'b1;
                            nextStep = cpuPkg::stepT0;
                        end
                        default: nextStep = cpuPkg::stepT0; // nop and unused codes
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          Gra,
    input  logic                          Grb,
    input  logic                          Grc,
    input  logic                          Rin,
    input  logic                          Rout,
    input  logic                          BAout,
    input  logic [cpuPkg::dataWidth-1:0]  IR,
    input  logic [cpuPkg::dataWidth-1:0]  busIn,
    output logic [cpuPkg::dataWidth-1:0]  regData
);

    logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];
    logic [cpuPkg::regSel-1:0]    sel;

    // Field select from the IR
    always_comb begin
        sel = '0;
        if (Gra) begin
            sel = IR[cpuPkg::raHi:cpuPkg::raLo];
        end else if (Grb) begin
            sel = IR[cpuPkg::rbHi:cpuPkg::rbLo];
        end else if (Grc) begin
            sel = IR[cpuPkg::rcHi:cpuPkg::rcLo];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (Rin) begin
            regs[sel] <= busIn;
        end
    end

    always_comb begin
        regData = '0;
        if (Rout || (BAout && sel != '0)) begin
            regData = regs[sel]; // R0 is zero under BAout
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [4:0]                    aluOp,
    input  logic [cpuPkg::dataWidth-1:0]  a,      // From Y
    input  logic [cpuPkg::dataWidth-1:0]  b,      // From the bus
    output logic [cpuPkg::dataWidth-1:0]  result
);

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd:   result = a + b;
            cpuPkg::aluSub:   result = a - b;
            cpuPkg::aluAnd:   result = a & b;
            cpuPkg::aluOr:    result = a | b;
            cpuPkg::aluPassB: result = b;
            default:          result = '0;
        endcase
    end

endmodule

// ==== memory.sv ====
`timescale 1ns/1ps

module memory (
    input  logic                          clk,
    input  logic [cpuPkg::addrWidth-1:0]  address,
    input  logic [cpuPkg::dataWidth-1:0]  writeData,
    input  logic                          write,
    output logic [cpuPkg::dataWidth-1:0]  readData,
    input  logic                          loadEnable,
    input  logic [cpuPkg::addrWidth-1:0]  loadAddress,
    input  logic [cpuPkg::dataWidth-1:0]  loadData
);

    logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];

    // Preload wins over CPU stores
    always_ff @(posedge clk) begin
        if (loadEnable) begin
            mem[loadAddress] <= loadData;
        end else if (write) begin
            mem[address] <= writeData;
        end
    end

    assign readData = mem[address]; // Asynchronous read

endmodule

// ==== miniCpu.sv ====
`timescale 1ns/1ps

module miniCpu (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stop,
    input  logic [cpuPkg::dataWidth-1:0]  inport,
    input  logic                          loadEnable,
    input  logic [cpuPkg::addrWidth-1:0]  loadAddress,
    input  logic [cpuPkg::dataWidth-1:0]  loadData,
    output logic [cpuPkg::dataWidth-1:0]  outport,
    output logic                          outportValid,
    output logic                          run
);

    logic pcOut, mdrOut, zOut, cOut, inportOut;
    logic marIn, zIn, pcIn, mdrIn, irIn, yIn, conIn, outportIn, incPc;
    logic memRead, memWrite, clear;
    logic Gra, Grb, Grc, Rin, Rout, BAout;
    logic [4:0] aluOp;

    logic [cpuPkg::dataWidth-1:0] pc, ir, mdr, y, z, inportReg;
    logic [cpuPkg::addrWidth-1:0] mar;
    logic [cpuPkg::dataWidth-1:0] bus, regData, aluResult, memData, cValue;
    logic                         conFf;
    logic                         conValue;

    // Sign-extended constant C
    assign cValue = {{(cpuPkg::dataWidth - cpuPkg::cHi - 1){ir[cpuPkg::cHi]}},
                     ir[cpuPkg::cHi:cpuPkg::cLo]};

    // Bus encoder picks one source at a time
    always_comb begin
        case (1'b1)
            Rout, BAout: bus = regData;
            pcOut:       bus = pc;
            mdrOut:      bus = mdr;
            zOut:        bus = z;
            cOut:        bus = cValue;
            inportOut:   bus = inportReg;
            default:     bus = '0;
        endcase
    end

    always_comb begin
        case (ir[cpuPkg::condHi:cpuPkg::condLo])
            cpuPkg::condZero:    conValue = (bus == '0);
            cpuPkg::condNonzero: conValue = (bus != '0);
            default:             conValue = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc           <= '0;
            ir           <= '0;
            conFf        <= 1'b0;
            outportValid <= 1'b0;
        end else begin
            if (incPc) begin
                pc <= pc + 1'b1;
            end else if (pcIn) begin
                pc <= aluResult; // Branch target straight from ALU
            end
            if (irIn) begin
                ir <= bus;
            end
            if (clear) begin
                conFf <= 1'b0;
            end else if (conIn) begin
                conFf <= conValue;
            end
            outportValid <= outportIn; // One-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        inportReg <= inport;
        if (marIn) begin
            mar <= bus[cpuPkg::addrWidth-1:0];
        end
        if (mdrIn) begin
            mdr <= memRead ? memData : bus;
        end
        if (yIn) begin
            y <= bus;
        end
        if (zIn) begin
            z <= aluResult;
        end
        if (outportIn) begin
            outport <= bus;
        end
    end

    control control_inst (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .IR        (ir),
        .conFf     (conFf),
        .pcOut     (pcOut),
        .mdrOut    (mdrOut),
        .zOut      (zOut),
        .cOut      (cOut),
        .inportOut (inportOut),
        .marIn     (marIn),
        .zIn       (zIn),
        .pcIn      (pcIn),
        .mdrIn     (mdrIn),
        .irIn      (irIn),
        .yIn       (yIn),
        .conIn     (conIn),
        .outportIn (outportIn),
        .incPc     (incPc),
        .aluOp     (aluOp),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .run       (run),
        .clear     (clear),
        .Gra       (Gra),
        .Grb       (Grb),
        .Grc       (Grc),
        .Rin       (Rin),
        .Rout      (Rout),
        .BAout     (BAout)
    );

    registerFile registerFile_inst (
        .clk     (clk),
        .reset   (reset),
        .Gra     (Gra),
        .Grb     (Grb),
        .Grc     (Grc),
        .Rin     (Rin),
        .Rout    (Rout),
        .BAout   (BAout),
        .IR      (ir),
        .busIn   (bus),
        .regData (regData)
    );

    alu alu_inst (
        .aluOp  (aluOp),
        .a      (y),
        .b      (bus),
        .result (aluResult)
    );

    memory memory_inst (
        .clk         (clk),
        .address     (mar),
        .writeData   (mdr),
        .write       (memWrite),
        .readData    (memData),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData)
    );

endmodule

// ==== cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    localparam int progCount = 6;
    localparam int progLen   = 48;
    localparam longint watchdogNs = progCount * (progLen * 8 + 600) * 40 + 2000;

    logic                                clk = 1'b0;
    logic                                reset;
    logic                                stop;
    logic [cpuPkg::dataWidth-1:0]        inport;
    logic                                loadEnable;
    logic [cpuPkg::addrWidth-1:0]        loadAddress;
    logic [cpuPkg::dataWidth-1:0]        loadData;
    logic [cpuPkg::dataWidth-1:0]        outport;
    logic                                outportValid;
    logic                                run;

    logic [31:0] lfsrState;
    logic [31:0] image [cpuPkg::memDepth];
    logic [31:0] expected [$];
    int          outIndex;
    logic        prevStop;

    miniCpu miniCpu_inst (
        .clk          (clk),
        .reset        (reset),
        .stop         (stop),
        .inport       (inport),
        .loadEnable   (loadEnable),
        .loadAddress  (loadAddress),
        .loadData     (loadData),
        .outport      (outport),
        .outportValid (outportValid),
        .run          (run)
    );

    always #20 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] want,
                              input string what);
        if (actual !== want) begin
            failRun($sformatf("error at %0t ns: %s: got %h, expected %h",
                              $time, what, actual, want));
        end
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic void buildProgram();
        logic [31:0] word;
        logic [4:0]  op;
        logic [3:0]  ra, rb, rc;
        logic [18:0] c;
        int          room;
        int          off;
        for (int a = 0; a < cpuPkg::memDepth; a++) begin
            image[a] = {7'h2b, a[8:0], ~a[7:0], a[7:0]}; // Data area fill
        end
        image[0] = {cpuPkg::opLdi, 4'd15, 4'd0, 19'd256}; // R15 is the data base
        for (int i = 1; i < progLen - 1; i++) begin
            case (4'(takeBits(4)))
                4'd0:    op = cpuPkg::opAdd;
                4'd1:    op = cpuPkg::opSub;
                4'd2:    op = cpuPkg::opAnd;
                4'd3:    op = cpuPkg::opOr;
                4'd4:    op = cpuPkg::opAddi;
                4'd5:    op = cpuPkg::opAndi;
                4'd6:    op = cpuPkg::opOri;
                4'd7:    op = cpuPkg::opLdi;
                4'd8:    op = cpuPkg::opLd;
                4'd9:    op = cpuPkg::opSt;
                4'd10:   op = cpuPkg::opBrzr;
                4'd11:   op = cpuPkg::opBrnz;
                4'd12:   op = cpuPkg::opIn;
                4'd15:   op = cpuPkg::opNop;
                default: op = cpuPkg::opOut;
            endcase
            ra = 4'(1 + takeBits(4) % 14); // Never R0 or R15
            rb = 4'(takeBits(4));
            rc = 4'(takeBits(4));
            c  = 19'(takeBits(19));
            case (op)
                cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr:
                    word = {op, ra, rb, rc, 15'd0};
                cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri:
                    word = {op, ra, rb, c};
                cpuPkg::opLdi:
                    word = {op, ra, rb[3] ? 4'd0 : rb, c}; // Mostly R0 base
                cpuPkg::opLd:
                    word = {op, ra, 4'd15, 16'd0, c[2:0]}; // Small window shared with st
                cpuPkg::opSt:
                    word = {op, rb, 4'd15, 16'd0, c[2:0]};
                cpuPkg::opBrzr, cpuPkg::opBrnz: begin
                    room = progLen - 2 - i; // Forward only and never past halt
                    off  = c[1:0];
                    if (off > room) begin
                        off = room;
                    end
                    word = {op, rb, 2'b00,
                            (op == cpuPkg::opBrnz) ? cpuPkg::condNonzero : cpuPkg::condZero,
                            19'(off)};
                end
                cpuPkg::opIn:  word = {op, ra, 23'd0};
                cpuPkg::opOut: word = {op, rb, 23'd0};
                default:       word = {cpuPkg::opNop, 27'd0};
            endcase
            image[i] = word;
        end
        image[progLen - 1] = {cpuPkg::opHalt, 27'd0};
    endfunction

    // Instruction-level model that fills the expected outport list
    function automatic void modelProgram(input logic [31:0] inVal);
        logic [31:0] regs [16];
        logic [31:0] mem [cpuPkg::memDepth];
        logic [31:0] pc, instr, cExt, base, addr;
        logic [3:0]  ra, rb, rc;
        logic [1:0]  cond;
        logic        halted;
        int          count;
        for (int r = 0; r < 16; r++) begin
            regs[r] = '0;
        end
        for (int a = 0; a < cpuPkg::memDepth; a++) begin
            mem[a] = image[a];
        end
        expected.delete();
        pc     = '0;
        halted = 1'b0;
        count  = 0;
        while (!halted && count < progLen) begin
            instr = mem[pc[8:0]];
            pc    = pc + 1;
            count++;
            ra    = instr[26:23];
            rb    = instr[22:19];
            rc    = instr[18:15];
            cond  = instr[20:19];
            cExt  = {{13{instr[18]}}, instr[18:0]};
            base  = (rb == 4'd0) ? 32'd0 : regs[rb];
            addr  = base + cExt;
            case (instr[31:27])
                cpuPkg::opAdd:  regs[ra] = regs[rb] + regs[rc];
                cpuPkg::opSub:  regs[ra] = regs[rb] - regs[rc];
                cpuPkg::opAnd:  regs[ra] = regs[rb] & regs[rc];
                cpuPkg::opOr:   regs[ra] = regs[rb] | regs[rc];
                cpuPkg::opAddi: regs[ra] = regs[rb] + cExt;
                cpuPkg::opAndi: regs[ra] = regs[rb] & cExt;
                cpuPkg::opOri:  regs[ra] = regs[rb] | cExt;
                cpuPkg::opLdi:  regs[ra] = addr;
                cpuPkg::opLd:   regs[ra] = mem[addr[8:0]];
                cpuPkg::opSt:   mem[addr[8:0]] = regs[ra];
                cpuPkg::opBrzr, cpuPkg::opBrnz: begin
                    if ((cond == cpuPkg::condZero && regs[ra] == 0) ||
                        (cond == cpuPkg::condNonzero && regs[ra] != 0)) begin
                        pc = pc + cExt;
                    end
                end
                cpuPkg::opIn:   regs[ra] = inVal;
                cpuPkg::opOut:  expected.push_back(regs[ra]);
                cpuPkg::opHalt: halted = 1'b1;
                default: ;
            endcase
        end
    endfunction

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            prevStop = 1'b0;
        end else if (prevStop && outportValid) begin
            failRun("outportValid pulsed while stop was held");
        end else if (outportValid && outIndex >= expected.size()) begin
            failRun("outportValid pulsed more often than the program has out instructions");
        end else begin
            if (outportValid) begin
                checkEqual(outport, expected[outIndex], "outport value");
                outIndex++;
            end
            prevStop = stop;
        end
    end

    task automatic runProgram();
        logic [31:0] inVal;
        int          stopAt;
        int          stopLen;
        int          cycle;
        logic        done;
        inVal   = takeBits(32);
        stopAt  = takeBits(8) % (progLen * 4);
        stopLen = 3 + takeBits(3);
        @(posedge clk);
        reset <= 1'b1;
        buildProgram();
        modelProgram(inVal);
        outIndex = 0;
        repeat (10) @(posedge clk);
        for (int a = 0; a < cpuPkg::memDepth; a++) begin
            @(posedge clk);
            loadEnable  <= 1'b1;
            loadAddress <= a[8:0];
            loadData    <= image[a];
            inport      <= inVal; // Held for the whole program
        end
        @(posedge clk);
        loadEnable <= 1'b0;
        reset      <= 1'b0;
        cycle = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (cycle == stopAt) begin
                stop <= 1'b1;
            end
            if (cycle == stopAt + stopLen) begin
                stop <= 1'b0;
            end
            cycle++;
            @(negedge clk);
            done = !run && !stop;
        end
        repeat (16) @(negedge clk); // Nothing may follow halt
        checkEqual(32'(outIndex), 32'(expected.size()), "outport pulse count");
        checkEqual({31'd0, run}, 32'd0, "run after halt");
    endtask

    initial begin
        lfsrState = 32'h77a340fa;
        reset       <= 1'b1;
        stop        <= 1'b0;
        inport      <= '0;
        loadEnable  <= 1'b0;
        loadAddress <= '0;
        loadData    <= '0;
        for (int p = 0; p < progCount; p++) begin
            runProgram();
        end
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(watchdogNs);
        failRun("watchdog expired: the CPU did not reach halt in time");
    end

endmodule

// ==== compile.f ====
cpuPkg.sv
control.sv
registerFile.sv
alu.sv
memory.sv
miniCpu.sv
cpuTb.sv

// ==== Bender.yml ====
package:
  name: mini_cpu

sources:
  - cpuPkg.sv
  - control.sv
  - registerFile.sv
  - alu.sv
  - memory.sv
  - miniCpu.sv
  - target: test
    files:
      - cpuTb.sv
